// File: up_pkg.sv
package up_pkg;

   localparam int DATA_W  = 8;
   localparam int NIB_W   = 4;
   localparam int REG_W   = 2;

   typedef logic [DATA_W-1:0] byte_t;   // Data and address word
   typedef logic [NIB_W-1:0]  nibble_t; // One instruction field
   typedef logic [REG_W-1:0]  reg_idx_t;

   // Opcode nibbles, two per program byte
   typedef enum nibble_t {
      op_add    = 4'h0,
      op_sub    = 4'h1,
      op_mul    = 4'h2,
      op_nand   = 4'h3,
      op_swap01 = 4'h4,
      op_swap12 = 4'h5,
      op_swap23 = 4'h6,
      op_beq    = 4'h7,
      op_nop8   = 4'h8,
      op_nop9   = 4'h9,
      op_pop    = 4'hA,
      op_push   = 4'hB,
      op_load   = 4'hC,
      op_store  = 4'hD,
      op_in     = 4'hE,
      op_nopf   = 4'hF
   } opcode_t;

   typedef enum logic [3:0] {
      load0  = 4'd0,
      load1  = 4'd1,
      load2  = 4'd2,
      load3  = 4'd3,
      load4  = 4'd4,
      fetch  = 4'd5,
      decode = 4'd6,
      exec1  = 4'd7,
      exec2  = 4'd8,
      exec3  = 4'd9
   } state_t;

   typedef enum logic [4:0] {
      add      = 5'd0,
      sub      = 5'd1,
      mul      = 5'd2,
      nand_op  = 5'd3,
      xor01    = 5'd4,
      xor12    = 5'd5,
      xor23    = 5'd6,
      const0   = 5'd7,
      const1   = 5'd8,
      const2   = 5'd9,
      const3   = 5'd10,
      pc_byte  = 5'd11, // Byte address of the pc nibble
      pc_inc   = 5'd12,
      pass_r3  = 5'd13,
      pass_r2  = 5'd14,
      sp_inc   = 5'd15,
      sp_pass  = 5'd16,
      sp_dec   = 5'd17,
      pass_mem = 5'd18
   } alu_op_t;

endpackage

// File: up_alu.sv
`timescale 1ns/10ps

module up_alu import up_pkg::*; (
   input  alu_op_t alu_op,
   input  byte_t   r0,
   input  byte_t   r1,
   input  byte_t   r2,
   input  byte_t   r3,
   input  byte_t   pc,
   input  byte_t   sp,
   input  byte_t   mem_rdata,
   output byte_t   result
);

   byte_t prod;

   assign prod = r1 * r2; // Low byte only

   always_comb begin
      case (alu_op)
         add:      result = r1 + r2;
         sub:      result = r1 - r2;
         mul:      result = prod;
         nand_op:  result = ~(r1 & r2);

         // Swap steps
         xor01:    result = r0 ^ r1;
         xor12:    result = r1 ^ r2;
         xor23:    result = r2 ^ r3;

         const0:   result = 8'h00;
         const1:   result = 8'h01;
         const2:   result = 8'h02;
         const3:   result = 8'h03;

         pc_byte:  result = {1'b0, pc[7:1]}; // Nibble to byte address
         pc_inc:   result = pc + 8'd1;
         pass_r3:  result = r3;
         pass_r2:  result = r2;
         sp_inc:   result = sp + 8'd1;
         sp_pass:  result = sp;
         sp_dec:   result = sp - 8'd1;
         default:  result = mem_rdata;
      endcase
   end

endmodule

// File: up_datapath.sv
`timescale 1ns/10ps

module up_datapath import up_pkg::*; #(
   parameter byte_t PC_RESET = 8'h08,
   parameter byte_t SP_RESET = 8'hFF
) (
   input  logic     clk,
   input  logic     nRst,
   input  alu_op_t  alu_op,
   input  logic     ir_we,
   input  logic     pc_we,
   input  logic     sp_we,
   input  logic     ale,
   input  logic     rf_we,
   input  logic     rf_from_alu,
   input  reg_idx_t rf_idx,
   input  byte_t    mem_rdata,
   output byte_t    mem_addr,
   output byte_t    mem_wdata,
   output logic     pc_odd,
   output logic     eq
);

   byte_t r0;
   byte_t r1;
   byte_t r2;
   byte_t r3;
   byte_t pc;
   byte_t sp;
   byte_t addr_latch;
   byte_t result;
   byte_t rf_wdata;
   logic  eq_flag;

   up_alu alu_inst (
      .alu_op    (alu_op),
      .r0        (r0),
      .r1        (r1),
      .r2        (r2),
      .r3        (r3),
      .pc        (pc),
      .sp        (sp),
      .mem_rdata (mem_rdata),
      .result    (result)
   );

   assign rf_wdata = rf_from_alu ? result : mem_rdata;

   always_ff @(posedge clk) begin
      if (rf_we) begin
         case (rf_idx)
            2'd0: r0 <= rf_wdata;
            2'd1: r1 <= rf_wdata;
            2'd2: r2 <= rf_wdata;
            2'd3: r3 <= rf_wdata;
         endcase
      end
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         pc         <= PC_RESET;
         sp         <= SP_RESET;
         addr_latch <= 8'h00;
         eq_flag    <= 1'b0;
      end else begin
         if (pc_we)
            pc <= result;
         if (sp_we)
            sp <= result;
         if (ale)
            addr_latch <= result;
         // Sampled at decode, registers are stable until exec1
         if (ir_we)
            eq_flag <= (r1 == r2);
      end
   end

   assign mem_addr  = addr_latch;
   assign mem_wdata = result;
   assign pc_odd    = pc[0];
   assign eq        = eq_flag;

endmodule

// File: up_ctrl.sv
`timescale 1ns/10ps

module up_ctrl import up_pkg::*; (
   input  logic     clk,
   input  logic     nRst,
   input  byte_t    mem_rdata,
   input  logic     pc_odd,
   input  logic     eq,
   output alu_op_t  alu_op,
   output logic     ir_we,
   output logic     pc_we,
   output logic     sp_we,
   output logic     ale,
   output logic     rf_we,
   output logic     rf_from_alu,
   output logic     mem_we,
   output reg_idx_t rf_idx
);

   state_t  state;
   state_t  state_nxt;
   opcode_t ir;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state <= load0;
         ir    <= op_add;
      end else begin
         state <= state_nxt;
         if (ir_we)
            ir <= opcode_t'(pc_odd ? mem_rdata[3:0] : mem_rdata[7:4]);
      end
   end

   always_comb begin
      alu_op      = pass_mem;
      ir_we       = 1'b0;
      pc_we       = 1'b0;
      sp_we       = 1'b0;
      ale         = 1'b0;
      rf_we       = 1'b0;
      rf_from_alu = 1'b1;
      rf_idx      = 2'd0;
      mem_we      = 1'b0;
      state_nxt   = fetch;
      case (state)
         load0: begin
            alu_op    = const0;
            ale       = 1'b1;
            state_nxt = load1;
         end
         load1, load2, load3, load4: begin
            // Register byte arrives one state after its address
            rf_we       = 1'b1;
            rf_from_alu = 1'b0;
            rf_idx      = reg_idx_t'(state - load1);
            ale         = 1'b1;
            case (state)
               load1:   alu_op = const1;
               load2:   alu_op = const2;
               load3:   alu_op = const3;
               default: alu_op = pc_byte;
            endcase
            state_nxt = (state == load4) ? fetch : state_t'(state + 4'd1);
         end
         fetch: begin
            alu_op    = pc_byte;
            ale       = 1'b1;
            state_nxt = decode;
         end
         decode: begin
            alu_op    = pc_inc;
            ir_we     = 1'b1;
            pc_we     = 1'b1;
            state_nxt = exec1;
         end
         exec1: begin
            state_nxt = exec2;
            case (ir)
               op_add, op_sub, op_mul, op_nand: begin
                  case (ir)
                     op_add:  alu_op = add;
                     op_sub:  alu_op = sub;
                     op_mul:  alu_op = mul;
                     default: alu_op = nand_op;
                  endcase
                  rf_we     = 1'b1;
                  state_nxt = fetch;
               end
               op_swap01: begin
                  alu_op = xor01;
                  rf_we  = 1'b1;
               end
               op_swap12: begin
                  alu_op = xor12;
                  rf_we  = 1'b1;
                  rf_idx = 2'd1;
               end
               op_swap23: begin
                  alu_op = xor23;
                  rf_we  = 1'b1;
                  rf_idx = 2'd2;
               end
               op_beq: begin
                  alu_op    = pass_r3;
                  pc_we     = eq;
                  state_nxt = fetch;
               end
               op_pop: begin
                  alu_op = sp_inc; // Pre-increment, address follows sp
                  sp_we  = 1'b1;
                  ale    = 1'b1;
               end
               op_push: begin
                  alu_op = sp_pass;
                  ale    = 1'b1;
               end
               op_load, op_store: begin
                  alu_op = pass_r3;
                  ale    = 1'b1;
               end
               op_in: begin
                  alu_op = const0;
                  ale    = 1'b1;
               end
               default: state_nxt = fetch; // Opcodes 8, 9, F
            endcase
         end
         exec2: begin
            case (ir)
               op_swap01: begin
                  alu_op    = xor01;
                  rf_we     = 1'b1;
                  rf_idx    = 2'd1;
                  state_nxt = exec3;
               end
               op_swap12: begin
                  alu_op    = xor12;
                  rf_we     = 1'b1;
                  rf_idx    = 2'd2;
                  state_nxt = exec3;
               end
               op_swap23: begin
                  alu_op    = xor23;
                  rf_we     = 1'b1;
                  rf_idx    = 2'd3;
                  state_nxt = exec3;
               end
               op_push: begin
                  alu_op    = sp_dec;
                  sp_we     = 1'b1;
                  state_nxt = exec3;
               end
               op_pop, op_load: begin
                  rf_we       = 1'b1;
                  rf_from_alu = 1'b0;
                  rf_idx      = 2'd2;
               end
               op_store: begin
                  alu_op = pass_r2;
                  mem_we = 1'b1;
               end
               op_in: begin
                  rf_we       = 1'b1;
                  rf_from_alu = 1'b0;
               end
               default: ;
            endcase
         end
         exec3: begin
            case (ir)
               op_swap01: begin
                  alu_op = xor01;
                  rf_we  = 1'b1;
               end
               op_swap12: begin
                  alu_op = xor12;
                  rf_we  = 1'b1;
                  rf_idx = 2'd1;
               end
               op_swap23: begin
                  alu_op = xor23;
                  rf_we  = 1'b1;
                  rf_idx = 2'd2;
               end
               op_push: begin
                  alu_op = pass_r2; // Latch still holds the old sp
                  mem_we = 1'b1;
               end
               default: ;
            endcase
         end
         default: state_nxt = fetch;
      endcase
   end

endmodule

// File: up_core.sv
`timescale 1ns/10ps

module up_core import up_pkg::*; #(
   parameter byte_t PC_RESET = 8'h08, // Nibble address of the first opcode
   parameter byte_t SP_RESET = 8'hFF
) (
   input  logic  clk,
   input  logic  nRst,
   input  byte_t mem_rdata,
   output byte_t mem_addr,
   output byte_t mem_wdata,
   output logic  mem_we
);

   alu_op_t  alu_op;
   logic     ir_we;
   logic     pc_we;
   logic     sp_we;
   logic     ale;
   logic     rf_we;
   logic     rf_from_alu;
   reg_idx_t rf_idx;
   logic     pc_odd;
   logic     eq;

   up_ctrl ctrl_inst (
      .clk         (clk),
      .nRst        (nRst),
      .mem_rdata   (mem_rdata),
      .pc_odd      (pc_odd),
      .eq          (eq),
      .alu_op      (alu_op),
      .ir_we       (ir_we),
      .pc_we       (pc_we),
      .sp_we       (sp_we),
      .ale         (ale),
      .rf_we       (rf_we),
      .rf_from_alu (rf_from_alu),
      .mem_we      (mem_we),
      .rf_idx      (rf_idx)
   );

   up_datapath #(
      .PC_RESET (PC_RESET),
      .SP_RESET (SP_RESET)
   ) datapath_inst (
      .clk         (clk),
      .nRst        (nRst),
      .alu_op      (alu_op),
      .ir_we       (ir_we),
      .pc_we       (pc_we),
      .sp_we       (sp_we),
      .ale         (ale),
      .rf_we       (rf_we),
      .rf_from_alu (rf_from_alu),
      .rf_idx      (rf_idx),
      .mem_rdata   (mem_rdata),
      .mem_addr    (mem_addr),
      .mem_wdata   (mem_wdata),
      .pc_odd      (pc_odd),
      .eq          (eq)
   );

endmodule

// File: up_core_assert.sv
`timescale 1ns/10ps

module up_core_assert_props import up_pkg::*; (
   input logic  clk,
   input logic  nRst,
   input logic  mem_we,
   input byte_t mem_addr
);

   logic [2:0] since_reset; // Saturating cycle count after release

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst)
         since_reset <= 3'd0;
      else if (since_reset != 3'd7)
         since_reset <= since_reset + 3'd1;
   end

   // Store and push both hold the strobe for one cycle
   single_cycle_we: assert property (
      @(posedge clk) disable iff (!nRst) mem_we |=> !mem_we
   ) else $error("mem_we stayed high for two cycles");

   no_we_in_load: assert property (
      @(posedge clk) disable iff (!nRst) (since_reset < 3'd5) |-> !mem_we
   ) else $error("mem_we went high during the register preload");

   addr_known: assert property (
      @(posedge clk) disable iff (!nRst) !$isunknown(mem_addr)
   ) else $error("mem_addr is unknown after reset");

endmodule

// File: up_core_tb.sv
`timescale 1ns/10ps

module up_core_tb
   import up_pkg::*;
();

   localparam int NUM_ROWS    = 14;
   localparam int STORE_LIMIT = 100;
   localparam int RUN_LIMIT   = NUM_ROWS * 120;

   typedef logic [3:0] row_idx_t;

   typedef struct packed {
      byte_t       b0;
      byte_t       b1;
      byte_t       b2;
      byte_t       b3;
      logic [31:0] prog;     // Eight nibbles with the first opcode on top
      byte_t       exp_addr;
      byte_t       exp_data;
   } row_t;

   logic     clk = 1'b0;
   logic     nRst;
   byte_t    mem_rdata;
   byte_t    mem_addr;
   byte_t    mem_wdata;
   logic     mem_we;

   byte_t    mem [256];
   logic     fill_en;
   row_idx_t fill_row;
   byte_t    write_count;  // Stores seen since the last fill
   row_t     rows [NUM_ROWS];
   int       cycle_count = 0;

   always #20 clk = ~clk;

   up_core #(
      .PC_RESET (8'h08),
      .SP_RESET (8'hFF)
   ) up_core_inst (
      .clk       (clk),
      .nRst      (nRst),
      .mem_rdata (mem_rdata),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_we    (mem_we)
   );

   bind up_core up_core_assert_props assert_inst (
      .clk      (clk),
      .nRst     (nRst),
      .mem_we   (mem_we),
      .mem_addr (mem_addr)
   );

   assign mem_rdata = mem[mem_addr]; // Asynchronous read

   function automatic byte_t image_byte(input row_idx_t r, input int a);
      case (a)
         0:          return rows[r].b0;
         1:          return rows[r].b1;
         2:          return rows[r].b2;
         3:          return rows[r].b3;
         4, 5, 6, 7: return byte_t'(rows[r].prog >> (8 * (7 - a)));
         default:    return 8'h00;
      endcase
   endfunction

   always @(posedge clk) begin
      if (fill_en) begin
         for (int a = 0; a < 256; a++)
            mem[byte_t'(a)] <= image_byte(fill_row, a);
         write_count <= 8'd0;
      end else if (mem_we) begin
         mem[mem_addr] <= mem_wdata;
         write_count   <= write_count + 8'd1;
      end
   end

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= RUN_LIMIT) begin
         $display("Run stopped after %0d cycles without reaching the end", RUN_LIMIT);
         $display("TEST FAILED");
         $fatal(1, "Run timeout");
      end
   end

   task automatic check_value(input string name, input byte_t actual, input byte_t expected);
      if (actual !== expected) begin
         $display("CHECK FAILED at %0t: %s is %02h, expected %02h",
                  $time, name, actual, expected);
         $display("TEST FAILED");
         $fatal(1, "Value mismatch");
      end
   endtask

   // r0 to r3 start as bytes 0 to 3
   task automatic load_table();
      // add then swaps and store gives 17 + 05
      rows[0]  = '{8'h5A, 8'h17, 8'h05, 8'h80, 32'h045D_0000, 8'h80, 8'h1C};
      // sub 17 - 25 wraps
      rows[1]  = '{8'h00, 8'h17, 8'h25, 8'h90, 32'h145D_0000, 8'h90, 8'hF2};
      // mul 19 * 27 = 513 keeps the low byte
      rows[2]  = '{8'h00, 8'h13, 8'h1B, 8'hA0, 32'h245D_0000, 8'hA0, 8'h01};
      // nand gives ~(F0 & 3C)
      rows[3]  = '{8'h00, 8'hF0, 8'h3C, 8'hB0, 32'h345D_0000, 8'hB0, 8'hCF};
      // swap12 then store
      rows[4]  = '{8'h00, 8'h66, 8'h77, 8'h40, 32'h5D00_0000, 8'h40, 8'h66};
      // swap23 and swap12 leave byte 1 in r2 and byte 2 in r3
      rows[5]  = '{8'h11, 8'h22, 8'h50, 8'h33, 32'h65D0_0000, 8'h50, 8'h22};
      // swap23 then store puts byte 3 at the address from byte 2
      rows[6]  = '{8'h11, 8'h22, 8'h60, 8'h44, 32'h6D00_0000, 8'h60, 8'h44};
      // beq taken to nibble 12 and the add sequence there
      rows[7]  = '{8'h00, 8'h21, 8'h21, 8'h0C, 32'h7DFF_045D, 8'h0C, 8'h42};
      // beq not taken falls into store
      rows[8]  = '{8'h00, 8'h21, 8'h30, 8'h0C, 32'h7DFF_045D, 8'h0C, 8'h30};
      // Lone push at the reset sp
      rows[9]  = '{8'h00, 8'h00, 8'h9E, 8'h00, 32'hB000_0000, 8'hFF, 8'h9E};
      // pop wraps sp to 0
      rows[10] = '{8'hC3, 8'h00, 8'h00, 8'h70, 32'hAD00_0000, 8'h70, 8'hC3};
      // load and store through r3 = 1
      rows[11] = '{8'h00, 8'h5B, 8'h00, 8'h01, 32'hCD00_0000, 8'h01, 8'h5B};
      // in overwrites r0 between the two swap01
      rows[12] = '{8'hE7, 8'h12, 8'h34, 8'h88, 32'h4E45_D000, 8'h88, 8'hE7};
      // Opcodes 8, 9 and F do nothing
      rows[13] = '{8'h00, 8'h3A, 8'h00, 8'h20, 32'h89F5_D000, 8'h20, 8'h3A};
   endtask

   task automatic apply_row(input row_idx_t r);
      int waited;
      @(posedge clk);
      nRst     <= 1'b0;
      fill_en  <= 1'b1;
      fill_row <= r;
      @(posedge clk);
      fill_en <= 1'b0;
      repeat (2) @(posedge clk);
      nRst <= 1'b1;
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (!mem_we && waited < STORE_LIMIT);
      if (!mem_we) begin
         $display("Row %0d: the core made no store within %0d cycles", r, STORE_LIMIT);
         $display("TEST FAILED");
         $fatal(1, "Store timeout");
      end
      check_value("mem_addr", mem_addr, rows[r].exp_addr);
      check_value("mem_wdata", mem_wdata, rows[r].exp_data);
      @(negedge clk); // Write edge has passed
      check_value("write_count", write_count, 8'd1);
   endtask

   initial begin
      nRst     <= 1'b0;
      fill_en  <= 1'b0;
      fill_row <= '0;
      load_table();
      for (int i = 0; i < NUM_ROWS; i++)
         apply_row(row_idx_t'(i));
      $display("TEST OK");
      $finish;
   end

endmodule

// File: files.f
up_pkg.sv
up_alu.sv
up_datapath.sv
up_ctrl.sv
up_core.sv
up_core_assert.sv
up_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module up_core_tb \
   -f files.f

./obj_dir/Vup_core_tb
